//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_core_pkg.sv
      - hdl/reg_file.sv
      - hdl/insn_decode.sv
      - hdl/alu.sv
      - hdl/pc_unit.sv
      - hdl/lsu.sv
      - hdl/rv_core.sv
  - target: test
    files:
      - verif/rv_core_tb.sv

//--- hdl/alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_defines.svh"

module alu (
  input  wire rv_core_pkg::word_t   a,
  input  wire rv_core_pkg::word_t   b,
  input  wire rv_core_pkg::alu_op_e alu_op,
  input  wire rv_isa_pkg::funct3_e  funct3,
  input  wire rv_core_pkg::word_t   rs1_data,
  input  wire rv_core_pkg::word_t   rs2_data,
  output rv_core_pkg::word_t        result,
  output logic                      branch_taken
);
  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_ADD:  result = a + b;
      rv_core_pkg::ALU_SUB:  result = a - b;
      rv_core_pkg::ALU_SLL:  result = a << shamt;
      rv_core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_core_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_core_pkg::ALU_XOR:  result = a ^ b;
      rv_core_pkg::ALU_SRL:  result = a >> shamt;
      rv_core_pkg::ALU_SRA:  result = rv_core_pkg::word_t'($signed(a) >>> shamt);
      rv_core_pkg::ALU_OR:   result = a | b;
      rv_core_pkg::ALU_AND:  result = a & b;
      default:               result = '0;
    endcase
  end

  // branch compare on register operands, independent of the operand muxes
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_BEQ:  branch_taken = (rs1_data == rs2_data);
      rv_isa_pkg::F3_BNE:  branch_taken = (rs1_data != rs2_data);
      rv_isa_pkg::F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_isa_pkg::F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_isa_pkg::F3_BLTU: branch_taken = (rs1_data < rs2_data);
      rv_isa_pkg::F3_BGEU: branch_taken = (rs1_data >= rs2_data);
      default:             branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/insn_decode.sv
`default_nettype none
`timescale 1ns/1ps

module insn_decode (
  input  wire rv_core_pkg::word_t insn,
  output rv_core_pkg::reg_idx_t   rs1_addr,
  output rv_core_pkg::reg_idx_t   rs2_addr,
  output rv_core_pkg::reg_idx_t   rd_addr,
  output rv_core_pkg::word_t      imm,
  output rv_core_pkg::alu_op_e    alu_op,
  output rv_core_pkg::op_a_sel_e  op_a_sel,
  output logic                    use_imm,
  output rv_core_pkg::wb_sel_e    wb_sel,
  output logic                    reg_we,
  output logic                    is_branch,
  output logic                    is_jal,
  output logic                    is_jalr,
  output logic                    mem_read,
  output logic                    mem_write,
  output rv_core_pkg::mem_size_e  mem_size,
  output logic                    load_unsigned,
  output logic                    is_ecall
);
  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_e funct3;
  logic [rv_isa_pkg::FUNCT7_W-1:0] funct7;
  logic alt;
  rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode   = rv_isa_pkg::opcode_e'(insn[rv_isa_pkg::OPCODE_W-1:0]);
  assign funct3   = rv_isa_pkg::funct3_e'(insn[14:12]);
  assign funct7   = insn[31:25];
  assign alt      = (funct7 == rv_isa_pkg::F7_ALT);
  assign rd_addr  = insn[11:7];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];

  // sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    imm           = imm_i;
    alu_op        = rv_core_pkg::ALU_ADD;
    op_a_sel      = rv_core_pkg::OP_A_RS1;
    use_imm       = 1'b0;
    wb_sel        = rv_core_pkg::WB_ALU;
    reg_we        = 1'b0;
    is_branch     = 1'b0;
    is_jal        = 1'b0;
    is_jalr       = 1'b0;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    mem_size      = rv_core_pkg::mem_size_e'(funct3[1:0]);
    load_unsigned = funct3[2];
    is_ecall      = 1'b0;
    case (opcode)
      rv_isa_pkg::LUI: begin
        imm    = imm_u;
        wb_sel = rv_core_pkg::WB_UIMM;
        reg_we = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        imm      = imm_u;
        op_a_sel = rv_core_pkg::OP_A_PC;
        use_imm  = 1'b1;
        reg_we   = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = rv_core_pkg::WB_PC4;
        reg_we = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        use_imm = 1'b1;
        is_jalr = (funct3 == rv_isa_pkg::F3_ADD_SUB);
        wb_sel  = rv_core_pkg::WB_PC4;
        reg_we  = is_jalr;
      end
      rv_isa_pkg::BRANCH: begin
        imm       = imm_b;
        // funct3 2 and 3 are reserved
        is_branch = (funct3[2:1] != 2'b01);
      end
      rv_isa_pkg::LOAD: begin
        use_imm  = 1'b1;
        wb_sel   = rv_core_pkg::WB_LOAD;
        mem_read = funct3 inside {rv_isa_pkg::F3_MEM_B, rv_isa_pkg::F3_MEM_H,
                                  rv_isa_pkg::F3_MEM_W, rv_isa_pkg::F3_MEM_BU,
                                  rv_isa_pkg::F3_MEM_HU};
        reg_we   = mem_read;
      end
      rv_isa_pkg::STORE: begin
        imm       = imm_s;
        use_imm   = 1'b1;
        mem_write = funct3 inside {rv_isa_pkg::F3_MEM_B, rv_isa_pkg::F3_MEM_H,
                                   rv_isa_pkg::F3_MEM_W};
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP: begin
        use_imm = (opcode == rv_isa_pkg::OP_IMM);
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            if (!use_imm && alt) alu_op = rv_core_pkg::ALU_SUB;
            else alu_op = rv_core_pkg::ALU_ADD;
          end
          rv_isa_pkg::F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
          rv_isa_pkg::F3_SR: begin
            if (alt) alu_op = rv_core_pkg::ALU_SRA;
            else alu_op = rv_core_pkg::ALU_SRL;
          end
          rv_isa_pkg::F3_OR:   alu_op = rv_core_pkg::ALU_OR;
          default:             alu_op = rv_core_pkg::ALU_AND;
        endcase
        // funct7 is immediate bits except for shifts
        if (use_imm) begin
          reg_we = !(funct3 inside {rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_SR}) ||
                   funct7 == '0 || (alt && funct3 == rv_isa_pkg::F3_SR);
        end else begin
          reg_we = funct7 == '0 ||
                   (alt && funct3 inside {rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_SR});
        end
      end
      rv_isa_pkg::SYSTEM: begin
        is_ecall = (insn[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/lsu.sv
`default_nettype none
`timescale 1ns/1ps

module lsu (
  input  wire                         rst,
  input  wire rv_core_pkg::word_t     addr,
  input  wire rv_core_pkg::word_t     store_data,
  input  wire                         mem_read,
  input  wire                         mem_write,
  input  wire rv_core_pkg::mem_size_e mem_size,
  input  wire                         load_unsigned,
  input  wire rv_core_pkg::word_t     dmem_rdata,
  output rv_core_pkg::word_t          dmem_addr,
  output rv_core_pkg::word_t          dmem_wdata,
  output rv_core_pkg::byte_en_t       dmem_be,
  output rv_core_pkg::word_t          load_data
);
  rv_core_pkg::byte_en_t be_base;
  rv_core_pkg::word_t rdata_shifted;

  assign dmem_addr = addr;

  // replicate so every lane carries the data, enables pick the lane
  always_comb begin
    case (mem_size)
      rv_core_pkg::SIZE_B: begin
        dmem_wdata = {4{store_data[7:0]}};
        be_base    = 4'b0001;
      end
      rv_core_pkg::SIZE_H: begin
        dmem_wdata = {2{store_data[15:0]}};
        be_base    = 4'b0011;
      end
      default: begin
        dmem_wdata = store_data;
        be_base    = 4'b1111;
      end
    endcase
  end

  assign dmem_be = (mem_write && !rst) ? rv_core_pkg::byte_en_t'(be_base << addr[1:0]) : '0;

  // bring the addressed byte or half down to bit 0
  assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (mem_size)
      rv_core_pkg::SIZE_B:
        load_data = {{24{rdata_shifted[7] & !load_unsigned}}, rdata_shifted[7:0]};
      rv_core_pkg::SIZE_H:
        load_data = {{16{rdata_shifted[15] & !load_unsigned}}, rdata_shifted[15:0]};
      default:
        load_data = dmem_rdata;
    endcase
  end

  always_comb begin
    if (!rst && (mem_read || mem_write)) begin
      a_natural_align: assert final ((mem_size == rv_core_pkg::SIZE_B) ||
                                     (mem_size == rv_core_pkg::SIZE_H && !addr[0]) ||
                                     (addr[1:0] == 2'b00));
    end
  end

endmodule

`default_nettype wire

//--- hdl/pc_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_defines.svh"

module pc_unit (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     halt,
  input  wire                     is_branch,
  input  wire                     branch_taken,
  input  wire                     is_jal,
  input  wire                     is_jalr,
  input  wire rv_core_pkg::word_t imm,
  input  wire rv_core_pkg::word_t jalr_target,
  output rv_core_pkg::word_t      pc,
  output rv_core_pkg::word_t      pc_plus4
);
  rv_core_pkg::word_t pc_next;

  assign pc_plus4 = pc + `XLEN'd4;

  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (is_jalr) begin
      pc_next = {jalr_target[`XLEN-1:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= `RESET_PC;
    else pc <= pc_next;
  end

  // targets come from decode and ALU, so alignment is a system property
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_defines.svh"

module reg_file (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      we,
  input  wire rv_core_pkg::reg_idx_t rd_addr,
  input  wire rv_core_pkg::reg_idx_t rs1_addr,
  input  wire rv_core_pkg::reg_idx_t rs2_addr,
  input  wire rv_core_pkg::word_t    rd_data,
  output rv_core_pkg::word_t         rs1_data,
  output rv_core_pkg::word_t         rs2_data
);
  rv_core_pkg::word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // asynchronous read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  a_x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0));

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core (
  input  wire                     clk,
  input  wire                     rst,
  output rv_core_pkg::word_t      imem_addr,
  input  wire rv_core_pkg::word_t imem_data,
  output rv_core_pkg::word_t      dmem_addr,
  output rv_core_pkg::word_t      dmem_wdata,
  output rv_core_pkg::byte_en_t   dmem_be,
  input  wire rv_core_pkg::word_t dmem_rdata,
  output logic                    halt
);
  rv_core_pkg::reg_idx_t rs1_addr, rs2_addr, rd_addr;
  rv_core_pkg::word_t imm, rs1_data, rs2_data, rd_data, alu_a, alu_b;
  rv_core_pkg::word_t alu_result, pc, pc_plus4, load_data;
  rv_core_pkg::alu_op_e alu_op;
  rv_core_pkg::op_a_sel_e op_a_sel;
  rv_core_pkg::wb_sel_e wb_sel;
  rv_core_pkg::mem_size_e mem_size;
  rv_isa_pkg::funct3_e funct3;
  logic use_imm, reg_we, is_branch, is_jal, is_jalr, mem_read, mem_write;
  logic load_unsigned, is_ecall, branch_taken;

  assign imem_addr = pc;
  assign funct3    = rv_isa_pkg::funct3_e'(imem_data[14:12]);
  assign halt      = is_ecall && !rst;
  assign alu_a     = (op_a_sel == rv_core_pkg::OP_A_PC) ? pc : rs1_data;
  assign alu_b     = use_imm ? imm : rs2_data;

  always_comb begin
    case (wb_sel)
      rv_core_pkg::WB_LOAD: rd_data = load_data;
      rv_core_pkg::WB_PC4:  rd_data = pc_plus4;
      rv_core_pkg::WB_UIMM: rd_data = imm;
      default:              rd_data = alu_result;
    endcase
  end

  insn_decode u_insn_decode (
    .insn(imem_data), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .imm(imm), .alu_op(alu_op), .op_a_sel(op_a_sel), .use_imm(use_imm), .wb_sel(wb_sel),
    .reg_we(reg_we), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .mem_read(mem_read), .mem_write(mem_write), .mem_size(mem_size),
    .load_unsigned(load_unsigned), .is_ecall(is_ecall)
  );

  // halted ECALL retires nothing
  reg_file u_reg_file (
    .clk(clk), .rst(rst), .we(reg_we && !halt), .rd_addr(rd_addr), .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .funct3(funct3), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .result(alu_result), .branch_taken(branch_taken)
  );

  pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .halt(halt), .is_branch(is_branch), .branch_taken(branch_taken),
    .is_jal(is_jal), .is_jalr(is_jalr), .imm(imm), .jalr_target(alu_result), .pc(pc),
    .pc_plus4(pc_plus4)
  );

  lsu u_lsu (
    .rst(rst), .addr(alu_result), .store_data(rs2_data), .mem_read(mem_read),
    .mem_write(mem_write), .mem_size(mem_size), .load_unsigned(load_unsigned),
    .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_be(dmem_be), .load_data(load_data)
  );

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`XLEN/8-1:0] byte_en_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic {OP_A_RS1, OP_A_PC} op_a_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_UIMM} wb_sel_e;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {SIZE_B = 2'd0, SIZE_H = 2'd1, SIZE_W = 2'd2} mem_size_e;

endpackage

`default_nettype wire

//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width
`define XLEN 32

// integer register file shape
`define NUM_REGS 32
`define REG_ADDR_W 5

`define RESET_PC 32'h0000_0000

`endif

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // instruction field widths
  parameter int OPCODE_W = 7;
  parameter int FUNCT3_W = 3;
  parameter int FUNCT7_W = 7;

  // funct7 value selecting sub and sra
  parameter logic [FUNCT7_W-1:0] F7_ALT = 7'b010_0000;

  typedef enum logic [OPCODE_W-1:0] {
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    BRANCH = 7'b110_0011,
    JALR   = 7'b110_0111,
    JAL    = 7'b110_1111,
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    SYSTEM = 7'b111_0011,
    AUIPC  = 7'b001_0111,
    LUI    = 7'b011_0111
  } opcode_e;

  // integer ops, shared by OP and OP-IMM
  typedef enum logic [FUNCT3_W-1:0] {
    F3_ADD_SUB = 3'd0,
    F3_SLL     = 3'd1,
    F3_SLT     = 3'd2,
    F3_SLTU    = 3'd3,
    F3_XOR     = 3'd4,
    F3_SR      = 3'd5,
    F3_OR      = 3'd6,
    F3_AND     = 3'd7
  } funct3_e;

  // branch conditions
  parameter funct3_e F3_BEQ  = funct3_e'(3'd0);
  parameter funct3_e F3_BNE  = funct3_e'(3'd1);
  parameter funct3_e F3_BLT  = funct3_e'(3'd4);
  parameter funct3_e F3_BGE  = funct3_e'(3'd5);
  parameter funct3_e F3_BLTU = funct3_e'(3'd6);
  parameter funct3_e F3_BGEU = funct3_e'(3'd7);

  // load and store widths, bit 2 marks unsigned loads
  parameter funct3_e F3_MEM_B  = funct3_e'(3'd0);
  parameter funct3_e F3_MEM_H  = funct3_e'(3'd1);
  parameter funct3_e F3_MEM_W  = funct3_e'(3'd2);
  parameter funct3_e F3_MEM_BU = funct3_e'(3'd4);
  parameter funct3_e F3_MEM_HU = funct3_e'(3'd5);

endpackage

`default_nettype wire

//--- rv_core.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/reg_file.sv
hdl/insn_decode.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/lsu.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

//--- verif/rv_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;
  localparam int MEM_WORDS = 64;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_LIMIT = 64;
  localparam rv_core_pkg::word_t ECALL = 32'h0000_0073;
  // every program stores x5 here before ECALL
  localparam rv_core_pkg::word_t RES_ADDR = 32'h40;
  localparam rv_core_pkg::word_t DATA_ADDR = 32'h44;

  logic clk;
  logic rst;
  rv_core_pkg::word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  rv_core_pkg::byte_en_t dmem_be;
  logic halt;

  rv_core_pkg::word_t imem [MEM_WORDS];
  rv_core_pkg::word_t dmem [MEM_WORDS];

  // program table, one entry per row except insn_q which holds all words
  string row_name [$];
  rv_core_pkg::word_t row_exp [$];
  rv_core_pkg::word_t row_pc [$];
  rv_core_pkg::byte_en_t row_be [$];
  int row_first [$];
  int row_len [$];
  rv_core_pkg::word_t insn_q [$];

  rv_core u_rv_core (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
    .dmem_rdata(dmem_rdata), .halt(halt)
  );

  always #10 clk = ~clk;

  // combinational reads, byte-masked writes at the edge
  assign imem_data = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_be[b]) dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
    end
  end

  // instruction encoders straight from the RV32I formats
  function automatic rv_core_pkg::word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_isa_pkg::OP};
  endfunction

  function automatic rv_core_pkg::word_t i_type(rv_isa_pkg::opcode_e op, int f3, int rd,
                                                int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::word_t s_type(int f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_isa_pkg::STORE};
  endfunction

  function automatic rv_core_pkg::word_t b_type(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_isa_pkg::BRANCH};
  endfunction

  function automatic rv_core_pkg::word_t u_type(rv_isa_pkg::opcode_e op, int rd, int imm20);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::word_t j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::JAL};
  endfunction

  function automatic rv_core_pkg::word_t addi(int rd, int rs1, int imm);
    return i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, rd, rs1, imm);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input rv_core_pkg::word_t exp,
                            input rv_core_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  task automatic check_be(input string name, input rv_core_pkg::byte_en_t exp,
                          input rv_core_pkg::byte_en_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %04b, actual %04b", name, exp, act));
    end
  endtask

  // zero words are unused slots, the SW of x5 and the ECALL close every program
  task automatic add_row(input string name, input rv_core_pkg::word_t exp,
                         input rv_core_pkg::byte_en_t be, input rv_core_pkg::word_t i0,
                         input rv_core_pkg::word_t i1 = '0, input rv_core_pkg::word_t i2 = '0,
                         input rv_core_pkg::word_t i3 = '0, input rv_core_pkg::word_t i4 = '0,
                         input rv_core_pkg::word_t i5 = '0);
    rv_core_pkg::word_t body [6];
    int first;
    body = '{i0, i1, i2, i3, i4, i5};
    first = insn_q.size();
    foreach (body[k]) begin
      if (body[k] != '0) insn_q.push_back(body[k]);
    end
    insn_q.push_back(s_type(rv_isa_pkg::F3_MEM_W, 5, 0, RES_ADDR));
    insn_q.push_back(ECALL);
    row_name.push_back(name);
    row_exp.push_back(exp);
    row_be.push_back(be);
    row_first.push_back(first);
    row_len.push_back(insn_q.size() - first);
    // ECALL is the last word, so the core halts on its address
    row_pc.push_back(4 * (insn_q.size() - first - 1));
  endtask

  // x1 = -1, x2 = 1; not-taken first branch adds 1, not-taken second adds 2
  task automatic branch_row(input string name, input int f3, input int rs1_second,
                            input rv_core_pkg::word_t exp);
    add_row(name, exp, 4'hf, addi(1, 0, -1), addi(2, 0, 1), b_type(f3, 1, 2, 8),
            addi(5, 5, 1), b_type(f3, rs1_second, 1, 8), addi(5, 5, 2));
  endtask

  task automatic build_table();
    int k;
    add_row("add_wrap", 32'h7fff_ffff, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80000),
            addi(2, 0, -1), r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 1, 2));
    add_row("sub", 32'h8000_0001, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80000), addi(2, 0, 1),
            r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 5, 2, 1));
    add_row("addi_neg", 32'hffff_f7ff, 4'hf, addi(1, 0, -2048), addi(5, 1, -1));
    add_row("slt_slti", 32'h0000_0002, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80000),
            i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLT, 2, 1, -1),
            r_type(0, rv_isa_pkg::F3_SLT, 3, 2, 1), r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 2, 2),
            r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 5, 3));
    add_row("sltu_sltiu", 32'h0000_0002, 4'hf, addi(1, 0, -1),
            i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLTU, 2, 0, -1),
            r_type(0, rv_isa_pkg::F3_SLTU, 3, 1, 0), r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 2, 2),
            r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 5, 3));
    add_row("xor_xori", 32'hedcb_af0f, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h12345),
            i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_XOR, 2, 1, -1), addi(3, 0, 'hf0),
            r_type(0, rv_isa_pkg::F3_XOR, 5, 2, 3));
    // srai by 4, then sra by 35 which uses only shamt 3
    add_row("sra_srai", 32'hff00_0000, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80000),
            i_type(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SR, 2, 1, 'h404), addi(3, 0, 35),
            r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR, 5, 2, 3));
    add_row("lui", 32'habcd_e000, 4'hf, u_type(rv_isa_pkg::LUI, 5, 'habcde));
    add_row("auipc", 32'h0000_1008, 4'hf, addi(0, 0, 0), addi(0, 0, 0),
            u_type(rv_isa_pkg::AUIPC, 5, 'h1));
    branch_row("beq", rv_isa_pkg::F3_BEQ, 1, 32'd1);
    branch_row("bne", rv_isa_pkg::F3_BNE, 1, 32'd2);
    branch_row("blt", rv_isa_pkg::F3_BLT, 2, 32'd2);
    branch_row("bge", rv_isa_pkg::F3_BGE, 2, 32'd1);
    branch_row("bltu", rv_isa_pkg::F3_BLTU, 2, 32'd1);
    branch_row("bgeu", rv_isa_pkg::F3_BGEU, 2, 32'd2);
    add_row("jal", 32'h0000_0004, 4'hf, j_type(1, 8), addi(5, 0, 'h100),
            r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 5, 1));
    // 15 + 2 lands on 16 once bit 0 is cleared
    add_row("jalr", 32'h0000_0008, 4'hf, addi(1, 0, 15),
            i_type(rv_isa_pkg::JALR, 0, 2, 1, 2), addi(5, 0, 'h100), addi(5, 0, 'h200),
            r_type(0, rv_isa_pkg::F3_ADD_SUB, 5, 5, 2));
    for (k = 0; k < 4; k++) begin
      add_row($sformatf("sb_lane%0d", k), 32'h85 << (8 * k), rv_core_pkg::byte_en_t'(1 << k),
              addi(1, 0, 'h85), s_type(rv_isa_pkg::F3_MEM_B, 1, 0, DATA_ADDR + k),
              i_type(rv_isa_pkg::LOAD, rv_isa_pkg::F3_MEM_W, 5, 0, DATA_ADDR));
    end
    // data word 80f07f81 at DATA_ADDR
    add_row("lb_lbu", 32'hffff_ff70, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80f08), addi(1, 1, -127),
            s_type(rv_isa_pkg::F3_MEM_W, 1, 0, DATA_ADDR),
            i_type(rv_isa_pkg::LOAD, rv_isa_pkg::F3_MEM_B, 2, 0, DATA_ADDR + 2),
            i_type(rv_isa_pkg::LOAD, rv_isa_pkg::F3_MEM_BU, 3, 0, DATA_ADDR + 3),
            r_type(0, rv_isa_pkg::F3_XOR, 5, 2, 3));
    // both halfword loads read 80f0, so only the extension differs
    add_row("lh_lhu", 32'hffff_0000, 4'hf, u_type(rv_isa_pkg::LUI, 1, 'h80f08), addi(1, 1, -127),
            s_type(rv_isa_pkg::F3_MEM_W, 1, 0, DATA_ADDR),
            i_type(rv_isa_pkg::LOAD, rv_isa_pkg::F3_MEM_H, 2, 0, DATA_ADDR + 2),
            i_type(rv_isa_pkg::LOAD, rv_isa_pkg::F3_MEM_HU, 3, 0, DATA_ADDR + 2),
            r_type(0, rv_isa_pkg::F3_XOR, 5, 2, 3));
  endtask

  task automatic run_row(input int r);
    rv_core_pkg::byte_en_t first_be;
    int cycles;
    int a;
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (a = 0; a < MEM_WORDS; a++) begin
      imem[a] = ECALL;
      dmem[a] = '0;
    end
    for (a = 0; a < row_len[r]; a++) begin
      imem[a] = insn_q[row_first[r] + a];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    first_be = '0;
    cycles = 0;
    // sample mid-cycle, the first store's enables are kept
    do begin
      @(negedge clk);
      if (first_be == '0) first_be = dmem_be;
      cycles++;
      if (!halt && cycles >= HALT_LIMIT) begin
        abort_run($sformatf("%s: program never halted within %0d cycles", row_name[r],
                            HALT_LIMIT));
      end
    end while (!halt);
    check_word({row_name[r], " pc"}, row_pc[r], imem_addr);
    check_word({row_name[r], " result"}, row_exp[r], dmem[RES_ADDR[7:2]]);
    check_be({row_name[r], " first store enables"}, row_be[r], first_be);
    repeat (2) begin
      @(negedge clk);
      if (!halt) abort_run($sformatf("%s: halt dropped after ECALL", row_name[r]));
      check_word({row_name[r], " held pc"}, row_pc[r], imem_addr);
    end
  endtask

  initial begin
    int a;
    clk = 1'b0;
    rst = 1'b1;
    for (a = 0; a < MEM_WORDS; a++) begin
      imem[a] = ECALL;
      dmem[a] = '0;
    end
    build_table();
    foreach (row_name[r]) begin
      run_row(r);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
